// ==== tb.f ====
+incdir+bench
logic/i51_pkg.sv
logic/i51_code_loader.sv
logic/i51_uart_tx.sv
logic/i51_sequencer.sv
logic/i51_datapath.sv
logic/i51_top.sv
bench/tb_i51.sv

// ==== Makefile ====
TOP = tb_i51

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f tb.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_i51_branches.svh ====
////////////////////////////////////////////////////////////
// branch and serial frame tests

task automatic branch_paths();
   int         s1;
   int         s2;
   int         s3;
   int         back;
   int         ret;
   logic [7:0] lim;
   begin_program();
   lim = 8'(3 + $urandom % 13);
   // cjne loop counting r2 up to lim
   reg_op(OP_MOV_RI, 3'd2, 8'h00);
   back = pc_asm;
   emit(8'(OP_INC_R) | 8'd2);
   emit(8'(OP_CJNE_RI) | 8'd2);
   emit(lim);
   s1 = pc_asm;
   emit(8'h00);
   patch(s1, back);
   m_r[2] = lim;
   m_c    = 1'b0;                              // last compare was equal
   reg_op(OP_MOV_AR, 3'd2, 8'h00);
   send_acc();
   // 10 minus 20 borrows and sets the carry
   acc_imm(OP_MOV_AI, 8'd10);
   acc_imm(OP_SUBB_AI, 8'd20);
   emit_branch(OP_JC, s1);  mark(8'hE1); patch(s1, pc_asm);  mark(8'h11);
   emit_branch(OP_JNC, s1); mark(8'h22); patch(s1, pc_asm);  mark(8'h23);
   exp_q.push_back(8'h11);
   exp_q.push_back(8'h22);
   exp_q.push_back(8'h23);
   acc_op(OP_CLR_C);
   emit_branch(OP_JC, s1);  mark(8'h33); patch(s1, pc_asm);
   emit_branch(OP_JNC, s1); mark(8'hE4); patch(s1, pc_asm);  mark(8'h44);
   exp_q.push_back(8'h33);
   exp_q.push_back(8'h44);
   // jz on zero, then on the nonzero marker left in a
   acc_op(OP_CLR_A);
   emit_branch(OP_JZ, s1);  mark(8'hE5); patch(s1, pc_asm);  mark(8'h55);
   emit_branch(OP_JZ, s1);  mark(8'h66); patch(s1, pc_asm);  mark(8'h67);
   exp_q.push_back(8'h55);
   exp_q.push_back(8'h66);
   exp_q.push_back(8'h67);
   // sjmp forward over a block, back into it, then forward out
   emit_branch(OP_SJMP, s1);
   back = pc_asm;
   mark(8'h77);
   emit_branch(OP_SJMP, s2);
   patch(s1, pc_asm);
   emit_branch(OP_SJMP, s3);
   patch(s3, back);
   patch(s2, pc_asm);
   mark(8'h88);
   exp_q.push_back(8'h77);
   exp_q.push_back(8'h88);
   // ljmp up to 0x1c0 and back down
   emit_op(OP_LJMP);
   emit(8'h01);
   emit(8'hC0);
   ret = pc_asm;
   mark(8'hAA);
   park();
   pc_asm = 'h1C0;
   mark(8'h99);
   emit_op(OP_LJMP);
   emit(8'(ret >> 8));
   emit(8'(ret));
   exp_q.push_back(8'h99);
   exp_q.push_back(8'hAA);
   run_program("branches");
endtask

task automatic serial_frame();
   begin_program();
   acc_imm(OP_MOV_AI, 8'h1D);                  // bit reversal would show
   send_acc();
   emit_op(OP_MOV_DPTR);
   emit(TX_STAT_ADDR[15:8]);
   emit(TX_STAT_ADDR[7:0]);
   emit_op(OP_MOVX_AD);
   m_a = 8'h01;                                // frame still going out
   send_acc();
   park();
   run_program("serial frame");
endtask

// ==== bench/tb_i51_tasks.svh ====
////////////////////////////////////////////////////////////
// serial line

task automatic send_byte(input logic [7:0] b);
   i_uart_rx = 1'b0;
   repeat (BIT_CYCLES) @(negedge i_clk);
   for (int i = 0; i < 8; i++) begin
      i_uart_rx = b[i];                        // lsb first
      repeat (BIT_CYCLES) @(negedge i_clk);
   end
   i_uart_rx = 1'b1;
   repeat (BIT_CYCLES) @(negedge i_clk);
endtask

task automatic recv_byte(output logic [7:0] b);
   logic [7:0] v;
   v = 8'h00;
   do @(negedge i_clk); while (o_uart_tx !== 1'b0);
   repeat (BIT_CYCLES / 2) @(negedge i_clk);
   check_bit("start bit", o_uart_tx, 1'b0);
   for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge i_clk);
      v = {v[6:0], o_uart_tx};                 // msb first
   end
   repeat (BIT_CYCLES) @(negedge i_clk);
   check_bit("stop bit", o_uart_tx, 1'b1);
   b = v;
endtask

task automatic load_program();
   for (int i = 0; i < 512; i++) send_byte(prog[i]);
endtask

task automatic do_reset();
   @(negedge i_clk);
   i_nrst    = 1'b0;
   i_uart_rx = 1'b1;
   rx_q.delete();
   wr_log.delete();
   repeat (5) @(negedge i_clk);
   i_nrst = 1'b1;
endtask

////////////////////////////////////////////////////////////
// program builders with the reference model

function automatic logic [7:0] rnd();
   return 8'($urandom());
endfunction

task automatic begin_program();
   for (int i = 0; i < 512; i++) prog[i] = 8'(i) ^ 8'(i >> 3);
   pc_asm = 0;
   m_a    = 8'h00;
   m_c    = 1'b0;
   for (int n = 0; n < 8; n++) m_r[n] = 8'h00;
   exp_q.delete();
endtask

task automatic emit(input logic [7:0] b);
   prog[pc_asm] = b;
   pc_asm++;
endtask

task automatic emit_op(input opcode_e op);
   emit(8'(op));
endtask

task automatic acc_imm(input opcode_e op, input logic [7:0] imm);
   logic [8:0] t;
   logic       borrow;
   emit_op(op);
   emit(imm);
   case (op)
      OP_MOV_AI: m_a = imm;
      OP_XRL_AI: m_a = m_a ^ imm;
      OP_ADD_AI: begin
         t   = {1'b0, m_a} + {1'b0, imm};
         m_a = t[7:0];
         m_c = t[8];
      end
      OP_SUBB_AI: begin
         borrow = ({1'b0, m_a} < {1'b0, imm} + {8'd0, m_c});
         m_a    = m_a - imm - {7'd0, m_c};
         m_c    = borrow;
      end
      default: ;
   endcase
endtask

task automatic acc_op(input opcode_e op);
   emit_op(op);
   case (op)
      OP_INC_A: m_a = m_a + 8'd1;              // carry untouched
      OP_DEC_A: m_a = m_a - 8'd1;
      OP_CLR_A: m_a = 8'h00;
      OP_CPL_A: m_a = ~m_a;
      OP_RLC:   {m_c, m_a} = {m_a, m_c};
      OP_CLR_C: m_c = 1'b0;
      default: ;
   endcase
endtask

task automatic reg_op(input opcode_e op, input logic [2:0] n, input logic [7:0] imm);
   logic [8:0] t;
   emit(8'(op) | {5'd0, n});
   case (op)
      OP_MOV_RI: begin
         emit(imm);
         m_r[n] = imm;
      end
      OP_MOV_RA: m_r[n] = m_a;
      OP_MOV_AR: m_a    = m_r[n];
      OP_INC_R:  m_r[n] = m_r[n] + 8'd1;
      OP_DEC_R:  m_r[n] = m_r[n] - 8'd1;
      OP_ADD_AR: begin
         t   = {1'b0, m_a} + {1'b0, m_r[n]};
         m_a = t[7:0];
         m_c = t[8];
      end
      default: ;
   endcase
endtask

// stash a in r7, poll busy, restore a and write the data register
task automatic send_code();
   reg_op(OP_MOV_RA, 3'd7, 8'h00);
   emit_op(OP_MOV_DPTR);
   emit(TX_STAT_ADDR[15:8]);
   emit(TX_STAT_ADDR[7:0]);
   emit_op(OP_MOVX_AD);
   emit_op(OP_JZ);
   emit(8'h02);                                // over the sjmp
   emit_op(OP_SJMP);
   emit(8'hFB);                                // back to the movx
   reg_op(OP_MOV_AR, 3'd7, 8'h00);
   emit_op(OP_MOV_DPTR);
   emit(TX_DATA_ADDR[15:8]);
   emit(TX_DATA_ADDR[7:0]);
   emit_op(OP_MOVX_DA);
endtask

task automatic send_acc();
   send_code();
   exp_q.push_back(m_a);
endtask

task automatic mark(input logic [7:0] v);
   acc_imm(OP_MOV_AI, v);
   send_code();
endtask

task automatic park();
   emit_op(OP_SJMP);
   emit(8'hFE);
endtask

// offset byte is always the last one of the branch
task automatic emit_branch(input opcode_e op, output int slot);
   emit_op(op);
   slot = pc_asm;
   emit(8'h00);
endtask

task automatic patch(input int slot, input int target);
   prog[slot] = 8'(target - (slot + 1));
endtask

////////////////////////////////////////////////////////////
// checks and test flow

task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_addr(input string what, input logic [CODE_AW-1:0] got,
                          input logic [CODE_AW-1:0] exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic report(input string name, input int err0);
   tests++;
   $display("test %-12s %0d errors", name, errors - err0);
endtask

task automatic run_program(input string name);
   int err0;
   err0 = errors;
   do_reset();
   load_program();
   while (rx_q.size() < exp_q.size()) @(negedge i_clk);
   foreach (exp_q[i]) check_byte($sformatf("%s byte %0d", name, i), rx_q[i], exp_q[i]);
   report(name, err0);
endtask

// ==== bench/tb_i51.sv ====
`timescale 1ns/10ps
module tb_i51 import i51_pkg::*; ();

   localparam int NUM_TESTS       = 5;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * (512 * 10 * BIT_CYCLES + 20000);
   localparam int SEED            = 32'h2dd94161;

   logic               i_clk;
   logic               i_nrst;
   logic               i_uart_rx;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   logic [7:0]         o_code_data;
   logic [7:0]         i_code_data = 8'h00;

   logic [7:0]         code_mem [512];  // external code memory
   logic [CODE_AW-1:0] wr_log [$];      // write addresses in arrival order
   logic [7:0]         rx_q [$];        // bytes seen on the serial output

   // program image and reference model
   logic [7:0]         prog [512];
   int                 pc_asm;
   logic [7:0]         m_a;
   logic               m_c;
   logic [7:0]         m_r [8];
   logic [7:0]         exp_q [$];

   int                 errors;
   int                 checks;
   int                 tests;

   i51_top i51_top_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // one cycle read latency, write on the edge
   always @(posedge i_clk) begin
      if (o_code_wr) begin
         code_mem[o_code_addr] <= o_code_data;
         wr_log.push_back(o_code_addr);
      end
      i_code_data <= code_mem[o_code_addr];
   end

   // serial output monitor
   initial begin
      logic [7:0] b;
      forever begin
         recv_byte(b);
         rx_q.push_back(b);
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   `include "tb_i51_tasks.svh"

   ////////////////////////////////////////////////////////////
   // tests

   task automatic loading();
      int err0;
      err0 = errors;
      begin_program();
      park();                                   // cpu idles on sjmp $
      for (int i = 2; i < 512; i++) prog[i] = rnd();
      do_reset();
      check_bit("tx line after reset", o_uart_tx, 1'b1);
      load_program();
      send_byte(8'hA5);                         // extra byte must not be written
      if (wr_log.size() != 512) begin
         $display("loader made %0d code writes instead of 512", wr_log.size());
         errors++;
      end
      foreach (wr_log[i]) check_addr("write address", wr_log[i], CODE_AW'(i));
      for (int i = 0; i < 512; i++) check_byte($sformatf("code[%0d]", i), code_mem[i], prog[i]);
      report("loading", err0);
   endtask

   task automatic accumulator_ops();
      begin_program();
      acc_imm(OP_MOV_AI, rnd());   send_acc();
      acc_imm(OP_ADD_AI, rnd());   send_acc();
      acc_imm(OP_SUBB_AI, rnd());  send_acc();  // carry from add
      acc_op(OP_INC_A);            send_acc();
      acc_op(OP_DEC_A);            send_acc();
      acc_op(OP_CPL_A);            send_acc();
      acc_imm(OP_XRL_AI, rnd());   send_acc();
      acc_op(OP_RLC);              send_acc();
      acc_imm(OP_SUBB_AI, rnd());  send_acc();
      acc_op(OP_CLR_C);
      acc_op(OP_RLC);              send_acc();  // zero rotates in
      acc_op(OP_CLR_A);            send_acc();
      park();
      run_program("accumulator");
   endtask

   task automatic register_ops();
      begin_program();
      for (int n = 0; n < 8; n++) reg_op(OP_MOV_RI, 3'(n), rnd());
      for (int n = 0; n < 8; n++) begin
         if (n % 2 == 0) reg_op(OP_INC_R, 3'(n), 8'h00);
         else            reg_op(OP_DEC_R, 3'(n), 8'h00);
      end
      acc_op(OP_CLR_A);
      for (int n = 0; n < 8; n++) reg_op(OP_ADD_AR, 3'(n), 8'h00);
      send_acc();                              // send overwrites r7
      for (int n = 0; n < 7; n++) begin
         reg_op(OP_MOV_AR, 3'(n), 8'h00);
         send_acc();
      end
      acc_imm(OP_MOV_AI, rnd());
      reg_op(OP_MOV_RA, 3'd5, 8'h00);
      reg_op(OP_INC_R, 3'd5, 8'h00);
      reg_op(OP_MOV_AR, 3'd5, 8'h00);
      send_acc();
      reg_op(OP_DEC_R, 3'd7, 8'h00);
      reg_op(OP_MOV_AR, 3'd7, 8'h00);
      send_acc();
      park();
      run_program("registers");
   endtask

   `include "tb_i51_branches.svh"

   initial begin
      void'($urandom(SEED));
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      loading();
      accumulator_ops();
      register_ops();
      branch_paths();
      serial_frame();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) $display("Done: no errors");
      else $display("Done: errors found");
      $finish;
   end

endmodule

// ==== logic/i51_top.sv ====
`timescale 1ns/10ps
module i51_top import i51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_uart_rx,
   output logic               o_uart_tx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_addr,
   output logic [7:0]         o_code_data,
   input  logic [7:0]         i_code_data
);

   logic               load_done;
   logic               ld_wr;
   logic [CODE_AW-1:0] ld_addr;
   logic [7:0]         ld_data;
   logic [CODE_AW-1:0] seq_addr;
   opcode_e            op;
   logic [7:0]         arg1;
   logic [7:0]         arg2;
   logic               exec;
   logic               branch;
   logic               tx_start;
   logic [7:0]         tx_data;
   logic               tx_busy;

   ////////////////////////////////////////////////////////////
   // code port, loader owns it until the image is complete

   assign o_code_addr = load_done ? seq_addr : ld_addr;
   assign o_code_wr   = ld_wr;
   assign o_code_data = ld_data;

   i51_code_loader i51_code_loader_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_uart_rx),
      .o_wr        (ld_wr),
      .o_addr      (ld_addr),
      .o_data      (ld_data),
      .o_load_done (load_done)
   );

   i51_sequencer i51_sequencer_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .i_branch    (branch),
      .o_code_addr (seq_addr),
      .o_op        (op),
      .o_arg1      (arg1),
      .o_arg2      (arg2),
      .o_exec      (exec)
   );

   i51_datapath i51_datapath_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_op       (op),
      .i_arg1     (arg1),
      .i_arg2     (arg2),
      .i_exec     (exec),
      .i_tx_busy  (tx_busy),
      .o_branch   (branch),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

   i51_uart_tx i51_uart_tx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_tx    (o_uart_tx),
      .o_busy  (tx_busy)
   );

endmodule

// ==== logic/i51_datapath.sv ====
`timescale 1ns/10ps
module i51_datapath import i51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  opcode_e    i_op,
   input  logic [7:0] i_arg1,
   input  logic [7:0] i_arg2,
   input  logic       i_exec,
   input  logic       i_tx_busy,
   output logic       o_branch,
   output logic       o_tx_start,
   output logic [7:0] o_tx_data
);

   logic [7:0]  acc;
   logic [7:0]  regs [8];
   logic        carry;
   logic [15:0] dptr;

   opcode_e     op_base;
   logic [2:0]  r_idx;
   logic [7:0]  r_sel;
   logic [8:0]  sum;
   logic [8:0]  diff;
   logic [7:0]  acc_nxt;
   logic [7:0]  r_nxt;
   logic        c_nxt;
   logic        acc_wr;
   logic        r_wr;
   logic        c_wr;
   logic        dptr_wr;
   logic        take;

   assign op_base = base_op(i_op);
   assign r_idx   = i_op[2:0];
   assign r_sel   = regs[r_idx];

   // bit 8 is carry out for add and borrow for subb
   assign sum  = {1'b0, acc} + {1'b0, (op_base == OP_ADD_AR) ? r_sel : i_arg1};
   assign diff = {1'b0, acc} - {1'b0, i_arg1} - {8'd0, carry};

   ////////////////////////////////////////////////////////////
   // execute

   always_comb begin
      acc_nxt = acc;
      r_nxt   = r_sel;
      c_nxt   = carry;
      acc_wr  = 1'b0;
      r_wr    = 1'b0;
      c_wr    = 1'b0;
      dptr_wr = 1'b0;
      take    = 1'b0;
      case (op_base)
         OP_MOV_AI:  begin acc_nxt = i_arg1;           acc_wr = 1'b1; end
         OP_MOV_AR:  begin acc_nxt = r_sel;            acc_wr = 1'b1; end
         OP_INC_A:   begin acc_nxt = acc + 8'd1;       acc_wr = 1'b1; end  // carry kept
         OP_DEC_A:   begin acc_nxt = acc - 8'd1;       acc_wr = 1'b1; end
         OP_CLR_A:   begin acc_nxt = 8'h00;            acc_wr = 1'b1; end
         OP_CPL_A:   begin acc_nxt = ~acc;             acc_wr = 1'b1; end
         OP_XRL_AI:  begin acc_nxt = acc ^ i_arg1;     acc_wr = 1'b1; end
         OP_ADD_AI,
         OP_ADD_AR: begin
            acc_nxt = sum[7:0];
            c_nxt   = sum[8];
            acc_wr  = 1'b1;
            c_wr    = 1'b1;
         end
         OP_SUBB_AI: begin
            acc_nxt = diff[7:0];
            c_nxt   = diff[8];
            acc_wr  = 1'b1;
            c_wr    = 1'b1;
         end
         OP_RLC: begin
            acc_nxt = {acc[6:0], carry};  // rotate through carry
            c_nxt   = acc[7];
            acc_wr  = 1'b1;
            c_wr    = 1'b1;
         end
         OP_CLR_C:   begin c_nxt = 1'b0; c_wr = 1'b1; end
         OP_MOVX_AD: begin
            // only the status flag is mapped for reads
            acc_nxt = (dptr == TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'h00;
            acc_wr  = 1'b1;
         end
         OP_MOV_RI:  begin r_nxt = i_arg1;      r_wr = 1'b1; end
         OP_MOV_RA:  begin r_nxt = acc;         r_wr = 1'b1; end
         OP_INC_R:   begin r_nxt = r_sel + 8'd1; r_wr = 1'b1; end
         OP_DEC_R:   begin r_nxt = r_sel - 8'd1; r_wr = 1'b1; end
         OP_MOV_DPTR: dptr_wr = 1'b1;
         OP_SJMP,
         OP_LJMP:    take = 1'b1;
         OP_JC:      take = carry;
         OP_JNC:     take = ~carry;
         OP_JZ:      take = (acc == 8'h00);
         OP_CJNE_RI: begin
            take  = (r_sel != i_arg1);
            c_nxt = (r_sel < i_arg1);
            c_wr  = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (i_exec) begin
         if (acc_wr)  acc         <= acc_nxt;
         if (c_wr)    carry       <= c_nxt;
         if (r_wr)    regs[r_idx] <= r_nxt;
         if (dptr_wr) dptr        <= {i_arg1, i_arg2};  // high byte first
      end
   end

   ////////////////////////////////////////////////////////////
   // branch decision and transmitter

   assign o_branch   = i_exec & take;
   assign o_tx_start = i_exec & (op_base == OP_MOVX_DA) & (dptr == TX_DATA_ADDR);
   assign o_tx_data  = acc;

endmodule

// ==== logic/i51_sequencer.sv ====
`timescale 1ns/10ps
module i51_sequencer import i51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_load_done,
   input  logic [7:0]         i_code_data,
   input  logic               i_branch,
   output logic [CODE_AW-1:0] o_code_addr,
   output opcode_e            o_op,
   output logic [7:0]         o_arg1,
   output logic [7:0]         o_arg2,
   output logic               o_exec
);

   seq_state_e         state;
   logic [CODE_AW-1:0] pc;
   opcode_e            op_q;
   opcode_e            op_cur;
   opcode_e            op_base;
   logic [7:0]         arg1_q;
   logic [7:0]         arg2_q;
   logic [1:0]         n_args;
   logic [7:0]         rel_off;
   logic [CODE_AW-1:0] rel_target;
   logic [15:0]        abs_target;

   ////////////////////////////////////////////////////////////
   // decode

   // opcode arrives from memory during decode0, held afterwards
   assign op_cur  = (state == SEQ_DECODE0) ? opcode_e'(i_code_data) : op_q;
   assign op_base = base_op(op_cur);

   // operand bytes following the opcode
   always_comb begin
      case (op_base)
         OP_LJMP,
         OP_MOV_DPTR,
         OP_CJNE_RI:  n_args = 2'd2;
         OP_MOV_AI,
         OP_ADD_AI,
         OP_SUBB_AI,
         OP_XRL_AI,
         OP_MOV_RI,
         OP_SJMP,
         OP_JC,
         OP_JNC,
         OP_JZ:       n_args = 2'd1;
         default:     n_args = 2'd0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // branch targets, pc already points past the instruction

   assign rel_off    = (op_base == OP_CJNE_RI) ? arg2_q : arg1_q;
   assign rel_target = pc + {{(CODE_AW-8){rel_off[7]}}, rel_off};
   assign abs_target = {arg1_q, arg2_q};

   ////////////////////////////////////////////////////////////
   // state and pc

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= SEQ_FETCH;
         pc    <= RESET_PC;
      end else begin
         case (state)
            SEQ_FETCH: begin
               if (i_load_done) begin  // hold until the image is in
                  state <= SEQ_DECODE0;
                  pc    <= pc + 1'b1;
               end
            end
            SEQ_DECODE0: begin
               if (n_args != 2'd0) begin
                  state <= SEQ_DECODE1;
                  pc    <= pc + 1'b1;
               end else begin
                  state <= SEQ_EXECUTE;
               end
            end
            SEQ_DECODE1: begin
               if (n_args == 2'd2) begin
                  state <= SEQ_DECODE2;
                  pc    <= pc + 1'b1;
               end else begin
                  state <= SEQ_EXECUTE;
               end
            end
            SEQ_DECODE2: state <= SEQ_EXECUTE;
            default: begin
               state <= SEQ_FETCH;
               if (i_branch) begin
                  pc <= (op_base == OP_LJMP) ? abs_target[CODE_AW-1:0] : rel_target;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // instruction latches

   always_ff @(posedge i_clk) begin
      if (state == SEQ_DECODE0) op_q   <= opcode_e'(i_code_data);
      if (state == SEQ_DECODE1) arg1_q <= i_code_data;
      if (state == SEQ_DECODE2) arg2_q <= i_code_data;
   end

   assign o_code_addr = pc;
   assign o_op        = op_q;
   assign o_arg1      = arg1_q;
   assign o_arg2      = arg2_q;
   assign o_exec      = (state == SEQ_EXECUTE);

endmodule

// ==== logic/i51_uart_tx.sv ====
`timescale 1ns/10ps
module i51_uart_tx import i51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_data,
   output logic       o_tx,
   output logic       o_busy
);

   tx_state_e            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [3:0]           bit_cnt;
   logic [7:0]           shreg;
   logic                 tick;

   assign tick = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));

   ////////////////////////////////////////////////////////////
   // frame sequencing

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_start) state <= TX_START;
            end
            TX_START: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) state <= TX_SEND;
            end
            default: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE;  // stop bit done
               end
            end
         endcase
      end
   end

   // ones shift in behind the data and form the stop bit
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) begin
         shreg <= i_data;
      end else if (state == TX_SEND && tick) begin
         shreg <= {shreg[6:0], 1'b1};
      end
   end

   assign o_tx = (state == TX_IDLE)  ? 1'b1 :
                 (state == TX_START) ? 1'b0 :
                                       shreg[7];  // msb first
   assign o_busy = (state != TX_IDLE);

endmodule

// ==== logic/i51_code_loader.sv ====
`timescale 1ns/10ps
module i51_code_loader import i51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_rx,
   output logic               o_wr,
   output logic [CODE_AW-1:0] o_addr,
   output logic [7:0]         o_data,
   output logic               o_load_done
);

   logic [1:0]           rx_sync;
   logic                 rx;
   rx_state_e            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [7:0]           shreg;
   logic                 mid_start;
   logic                 full_bit;

   assign rx        = rx_sync[1];
   assign mid_start = (cnt == BIT_CNT_W'(BIT_CYCLES/2 - 1));
   assign full_bit  = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));
   assign o_data    = shreg;

   ////////////////////////////////////////////////////////////
   // receiver

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;  // line idles high
      else         rx_sync <= {rx_sync[0], i_rx};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
         shreg <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx) state <= RX_START;
            end
            RX_START: begin
               cnt <= mid_start ? '0 : cnt + 1'b1;
               if (mid_start) begin
                  state <= rx ? RX_IDLE : RX_DATA;  // glitch goes back to idle
                  shreg <= 8'h80;                   // marker walks down to bit 0
               end
            end
            RX_DATA: begin
               cnt <= full_bit ? '0 : cnt + 1'b1;
               if (full_bit) begin
                  shreg <= {rx, shreg[7:1]};        // lsb first
                  if (shreg[0]) state <= RX_STOP;   // eighth bit taken
               end
            end
            default: begin                          // stop bit
               cnt <= full_bit ? '0 : cnt + 1'b1;
               if (full_bit) state <= RX_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // code write and address counter

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_wr        <= 1'b0;
         o_addr      <= '0;
         o_load_done <= 1'b0;
      end else begin
         o_wr <= (state == RX_STOP) && full_bit && !o_load_done;
         if (o_wr) begin
            o_addr <= o_addr + 1'b1;               // wraps 511 -> 0
            if (o_addr == '1) o_load_done <= 1'b1;
         end
      end
   end

endmodule

// ==== logic/i51_pkg.sv ====
package i51_pkg;

   ////////////////////////////////////////////////////////////
   // serial timing and address map

   localparam int BIT_CYCLES = 104;                 // clocks per serial bit
   localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);  // width of bit period counters
   localparam int CODE_AW    = 9;                   // 512 byte code space

   localparam logic [CODE_AW-1:0] RESET_PC = '0;

   localparam logic [15:0] TX_DATA_ADDR = 16'h0201; // movx @dptr,a sends a
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200; // movx a,@dptr reads busy

   ////////////////////////////////////////////////////////////
   // state encodings

   typedef enum logic [2:0] {
      SEQ_FETCH,
      SEQ_DECODE0,
      SEQ_DECODE1,
      SEQ_DECODE2,
      SEQ_EXECUTE
   } seq_state_e;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   ////////////////////////////////////////////////////////////
   // opcodes, register forms carry rn in bits 2:0

   typedef enum logic [7:0] {
      OP_LJMP     = 8'h02,  // ljmp addr16
      OP_INC_A    = 8'h04,
      OP_INC_R    = 8'h08,
      OP_DEC_A    = 8'h14,
      OP_DEC_R    = 8'h18,
      OP_ADD_AI   = 8'h24,
      OP_ADD_AR   = 8'h28,
      OP_RLC      = 8'h33,
      OP_JC       = 8'h40,
      OP_JNC      = 8'h50,
      OP_JZ       = 8'h60,
      OP_XRL_AI   = 8'h64,
      OP_MOV_AI   = 8'h74,
      OP_MOV_RI   = 8'h78,
      OP_SJMP     = 8'h80,
      OP_MOV_DPTR = 8'h90,  // mov dptr,#hi,#lo
      OP_SUBB_AI  = 8'h94,
      OP_CJNE_RI  = 8'hB8,  // cjne rn,#imm,rel
      OP_CLR_C    = 8'hC3,
      OP_MOVX_AD  = 8'hE0,
      OP_CLR_A    = 8'hE4,
      OP_MOV_AR   = 8'hE8,
      OP_MOVX_DA  = 8'hF0,
      OP_CPL_A    = 8'hF4,
      OP_MOV_RA   = 8'hF8
   } opcode_e;

   // bit 3 marks the register forms among the kept opcodes
   function automatic opcode_e base_op(input opcode_e op);
      return op[3] ? opcode_e'({op[7:3], 3'b000}) : op;
   endfunction

endpackage
